// ==== Makefile ====
# Verilator build and regression run for the object render path

SIM = obj_dir/Vtb_obj_render

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --assert --top-module tb_obj_render -f src.f
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== obj_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_fetcher #(
  parameter int MAX_SPRITES = 10
) (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     drawing,
  input  ppu_obj_pkg::pixel_coord_t     pixel_x,
  input  ppu_obj_pkg::obj_entry_t       obj_buf [MAX_SPRITES],
  input  wire logic [MAX_SPRITES-1:0]   line_active,
  input  ppu_obj_pkg::pixel_coord_t     line_ly,
  input  wire logic                     line_start_d,
  output logic                          vram_rd,
  output ppu_obj_pkg::vram_addr_t       vram_addr,
  input  wire logic [7:0]               vram_rdata,
  output logic                          stall,
  output logic                          push,
  output ppu_obj_pkg::obj_row_t         push_row
);

  ppu_obj_pkg::fetch_state_t state;
  ppu_obj_pkg::fetch_phase_t phase;

  logic [MAX_SPRITES-1:0]  pending;
  logic [MAX_SPRITES-1:0]  pending_eff;
  logic [MAX_SPRITES-1:0]  hit;
  logic [3:0]              hit_idx;
  logic                    hit_take;
  logic                    stall_q;

  ppu_obj_pkg::obj_entry_t cur_obj;
  logic [7:0]              low_byte;
  logic [2:0]              tile_row;
  ppu_obj_pkg::vram_addr_t row_addr;
  ppu_obj_pkg::obj_row_t   row_dec;

  // marks reloaded by line_start_d are already usable on that cycle
  assign pending_eff = line_start_d ? line_active : pending;

  always_comb begin
    for (int i = 0; i < MAX_SPRITES; i++) begin
      hit[i] = pending_eff[i] &&
               ({1'b0, pixel_x} + 9'(ppu_obj_pkg::OBJ_X_OFFSET) >= {1'b0, obj_buf[i].x_pos}) &&
               (pixel_x < obj_buf[i].x_pos);
    end
  end

  // lowest index wins
  always_comb begin
    hit_idx = '0;
    for (int i = MAX_SPRITES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        hit_idx = 4'(i);
      end
    end
  end

  assign hit_take = drawing && (state == ppu_obj_pkg::fetch_idle) && (|hit) &&
                    (pixel_x < ppu_obj_pkg::SCREEN_WIDTH);

  // hold the pixel at pixel_x back already on the hit cycle
  assign stall = stall_q | hit_take;

  always_comb begin
    tile_row = 3'(line_ly + ppu_obj_pkg::OBJ_Y_OFFSET - cur_obj.y_pos);
    if (cur_obj.attr[ppu_obj_pkg::ATTR_Y_FLIP]) begin
      tile_row = ~tile_row;
    end
    row_addr = ppu_obj_pkg::OBJ_TILE_BASE + {4'd0, cur_obj.tile_idx, 4'd0} +
               {12'd0, tile_row, 1'b0};
  end

  assign vram_rd   = ((state == ppu_obj_pkg::fetch_low) || (state == ppu_obj_pkg::fetch_high)) &&
                     (phase == ppu_obj_pkg::phase_addr);
  assign vram_addr = (state == ppu_obj_pkg::fetch_high) ? row_addr + 16'd1 : row_addr;

  // high byte is taken straight from the read data
  always_comb begin
    logic [2:0] b;
    for (int i = 0; i < 8; i++) begin
      b = cur_obj.attr[ppu_obj_pkg::ATTR_X_FLIP] ? 3'(i) : 3'(7 - i);
      row_dec[i].color = {vram_rdata[b], low_byte[b]};
      row_dec[i].valid = vram_rdata[b] | low_byte[b];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= ppu_obj_pkg::fetch_idle;
      phase   <= ppu_obj_pkg::phase_addr;
      stall_q <= 1'b0;
      push    <= 1'b0;
      pending <= '0;
    end else begin
      push <= 1'b0;
      if (line_start_d && (state != ppu_obj_pkg::fetch_idle)) begin
        // a new line drops any fetch in flight
        state   <= ppu_obj_pkg::fetch_idle;
        phase   <= ppu_obj_pkg::phase_addr;
        stall_q <= 1'b0;
        pending <= line_active;
      end else begin
        if (line_start_d) begin
          pending <= line_active;
        end
        unique case (state)
          ppu_obj_pkg::fetch_idle: begin
            if (hit_take) begin
              pending[hit_idx] <= 1'b0;
              stall_q          <= 1'b1;
              state            <= ppu_obj_pkg::fetch_low;
              phase            <= ppu_obj_pkg::phase_addr;
            end
          end
          ppu_obj_pkg::fetch_low: begin
            if (phase == ppu_obj_pkg::phase_addr) begin
              phase <= ppu_obj_pkg::phase_data;
            end else begin
              phase <= ppu_obj_pkg::phase_addr;
              state <= ppu_obj_pkg::fetch_high;
            end
          end
          ppu_obj_pkg::fetch_high: begin
            if (phase == ppu_obj_pkg::phase_addr) begin
              phase <= ppu_obj_pkg::phase_data;
            end else begin
              phase <= ppu_obj_pkg::phase_addr;
              state <= ppu_obj_pkg::fetch_push;
              push  <= 1'b1;
            end
          end
          ppu_obj_pkg::fetch_push: begin
            stall_q <= 1'b0;
            state   <= ppu_obj_pkg::fetch_idle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit_take) begin
      cur_obj <= obj_buf[hit_idx];
    end
    if ((state == ppu_obj_pkg::fetch_low) && (phase == ppu_obj_pkg::phase_data)) begin
      low_byte <= vram_rdata;
    end
    if ((state == ppu_obj_pkg::fetch_high) && (phase == ppu_obj_pkg::phase_data)) begin
      push_row <= row_dec;
    end
  end

  a_rd_single: assert property (@(posedge clk) disable iff (reset) vram_rd |=> !vram_rd);

  a_push_stalled: assert property (@(posedge clk) disable iff (reset) push |-> stall);

endmodule

`default_nettype wire

// ==== obj_line_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_line_select #(
  parameter int MAX_SPRITES = 10
) (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     oam_wr,
  input  wire logic [3:0]               oam_index,
  input  ppu_obj_pkg::obj_entry_t       oam_entry,
  input  wire logic                     line_start,
  input  ppu_obj_pkg::pixel_coord_t     ly,
  output ppu_obj_pkg::obj_entry_t       obj_buf [MAX_SPRITES],
  output logic [MAX_SPRITES-1:0]        line_active,
  output ppu_obj_pkg::pixel_coord_t     line_ly,
  output logic                          line_start_d
);

  // entry payload, the valid bits are kept apart so reset can clear them
  ppu_obj_pkg::obj_entry_t buf_q [MAX_SPRITES];
  logic [MAX_SPRITES-1:0]  buf_valid;
  logic [MAX_SPRITES-1:0]  in_range;

  always_ff @(posedge clk) begin
    if (oam_wr) begin
      buf_q[oam_index] <= oam_entry;
    end
  end

  always_comb begin
    for (int i = 0; i < MAX_SPRITES; i++) begin
      obj_buf[i]       = buf_q[i];
      obj_buf[i].valid = buf_valid[i];
    end
  end

  // row inside the object is ly + 16 - y_pos, a miss wraps above 7
  always_comb begin
    for (int i = 0; i < MAX_SPRITES; i++) begin
      in_range[i] = buf_valid[i] &&
                    ((ly + ppu_obj_pkg::OBJ_Y_OFFSET - buf_q[i].y_pos) < 8'd8);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      buf_valid    <= '0;
      line_active  <= '0;
      line_ly      <= '0;
      line_start_d <= 1'b0;
    end else begin
      if (oam_wr) begin
        buf_valid[oam_index] <= oam_entry.valid;
      end
      if (line_start) begin
        line_active <= in_range;
        line_ly     <= ly;
      end
      line_start_d <= line_start;
    end
  end

  a_oam_index_range: assert property (@(posedge clk) disable iff (reset)
    oam_wr |-> (int'(oam_index) < MAX_SPRITES));

endmodule

`default_nettype wire

// ==== obj_pixel_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_pixel_mixer (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     drawing,
  input  wire logic                     line_start,
  input  wire logic                     stall,
  input  wire logic                     push,
  input  ppu_obj_pkg::obj_row_t         push_row,
  output ppu_obj_pkg::pixel_coord_t     pixel_x,
  output logic                          pixel_valid,
  output ppu_obj_pkg::pixel_coord_t     pixel_out_x,
  output ppu_obj_pkg::obj_color_t       pixel_color
);

  ppu_obj_pkg::obj_row_t queue;
  ppu_obj_pkg::obj_row_t merged;
  ppu_obj_pkg::obj_row_t shifted;
  logic                  emit;

  assign emit = drawing && !stall && !line_start && (pixel_x < ppu_obj_pkg::SCREEN_WIDTH);

  // an earlier object keeps its opaque pixels
  always_comb begin
    merged = queue;
    if (push) begin
      for (int i = 0; i < 8; i++) begin
        if (!queue[i].valid) begin
          merged[i] = push_row[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 7; i++) begin
      shifted[i] = merged[i + 1];
    end
    // empty slot enters at the right
    shifted[7] = '0;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      queue       <= '0;
      pixel_x     <= '0;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= emit;
      if (line_start) begin
        queue   <= '0;
        pixel_x <= '0;
      end else begin
        if (emit) begin
          queue   <= shifted;
          pixel_x <= pixel_x + 8'd1;
        end else if (push) begin
          queue <= merged;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      pixel_out_x <= pixel_x;
      pixel_color <= merged[0].color;
    end
  end

  a_x_in_screen: assert property (@(posedge clk) disable iff (reset)
    pixel_x <= ppu_obj_pkg::SCREEN_WIDTH);

endmodule

`default_nettype wire

// ==== obj_render_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_render_top #(
  parameter int MAX_SPRITES = 10
) (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     oam_wr,
  input  wire logic [3:0]               oam_index,
  input  ppu_obj_pkg::obj_entry_t       oam_entry,
  input  wire logic                     line_start,
  input  ppu_obj_pkg::pixel_coord_t     ly,
  input  wire logic                     drawing,
  output logic                          vram_rd,
  output ppu_obj_pkg::vram_addr_t       vram_addr,
  input  wire logic [7:0]               vram_rdata,
  output logic                          pixel_valid,
  output ppu_obj_pkg::pixel_coord_t     pixel_out_x,
  output ppu_obj_pkg::obj_color_t       pixel_color
);

  ppu_obj_pkg::obj_entry_t   obj_buf [MAX_SPRITES];
  logic [MAX_SPRITES-1:0]    line_active;
  ppu_obj_pkg::pixel_coord_t line_ly;
  logic                      line_start_d;
  ppu_obj_pkg::pixel_coord_t pixel_x;
  logic                      stall;
  logic                      push;
  ppu_obj_pkg::obj_row_t     push_row;

  obj_line_select #(.MAX_SPRITES(MAX_SPRITES)) i_line_select (
    .clk, .reset, .oam_wr, .oam_index, .oam_entry, .line_start, .ly,
    .obj_buf, .line_active, .line_ly, .line_start_d
  );

  obj_fetcher #(.MAX_SPRITES(MAX_SPRITES)) i_fetcher (
    .clk, .reset, .drawing, .pixel_x, .obj_buf, .line_active, .line_ly, .line_start_d,
    .vram_rd, .vram_addr, .vram_rdata, .stall, .push, .push_row
  );

  // queue and pixel counter
  obj_pixel_mixer i_mixer (
    .clk, .reset, .drawing, .line_start, .stall, .push, .push_row,
    .pixel_x, .pixel_valid, .pixel_out_x, .pixel_color
  );

endmodule

`default_nettype wire

// ==== ppu_obj_pkg.sv ====
`default_nettype none

package ppu_obj_pkg;

  // screen x, screen y and line number
  typedef logic [7:0] pixel_coord_t;

  // byte address into video memory
  typedef logic [15:0] vram_addr_t;

  // 2 bit colour number, 0 is transparent
  typedef logic [1:0] obj_color_t;

  // one object buffer entry, coordinates carry the hardware offsets
  typedef struct packed {
    pixel_coord_t y_pos;
    pixel_coord_t x_pos;
    logic [7:0]   tile_idx;
    logic [7:0]   attr;
    logic         valid;
  } obj_entry_t;

  // valid marks a slot that holds an opaque object pixel
  typedef struct packed {
    obj_color_t color;
    logic       valid;
  } obj_pixel_t;

  // slot 0 is the next pixel to be shown
  typedef obj_pixel_t [7:0] obj_row_t;

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_low,
    fetch_high,
    fetch_push
  } fetch_state_t;

  // each byte read takes an address cycle and a data cycle
  typedef enum logic {
    phase_addr,
    phase_data
  } fetch_phase_t;

  localparam vram_addr_t   OBJ_TILE_BASE = 16'h8000;
  localparam pixel_coord_t OBJ_Y_OFFSET  = 8'd16;
  localparam pixel_coord_t OBJ_X_OFFSET  = 8'd8;
  localparam pixel_coord_t SCREEN_WIDTH  = 8'd160;

  // flip flags in attr
  localparam int ATTR_X_FLIP = 5;
  localparam int ATTR_Y_FLIP = 6;

endpackage

`default_nettype wire

// ==== src.f ====
ppu_obj_pkg.sv
obj_line_select.sv
obj_fetcher.sv
obj_pixel_mixer.sv
obj_render_top.sv
tb_obj_render.sv

// ==== tb_obj_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_obj_render;

  localparam int MAX_SPRITES = 10;
  localparam int NUM_ROWS = 7;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * (160 + 6 * MAX_SPRITES + 40) + 16;

  typedef enum int {
    MODE_SPREAD,
    MODE_OVERLAP,
    MODE_SAME_X,
    MODE_FLIPPED,
    MODE_OFF_LINE
  } place_mode_t;

  // one row per line: name, ly, object count, placement
  string names [NUM_ROWS] = '{"spread_full", "spread_few", "overlap", "same_x",
                              "flipped", "off_line", "overlap_full"};
  int lines [NUM_ROWS] = '{40, 0, 77, 120, 9, 63, 143};
  int counts [NUM_ROWS] = '{10, 3, 6, 4, 8, 10, 10};
  place_mode_t modes [NUM_ROWS] = '{MODE_SPREAD, MODE_SPREAD, MODE_OVERLAP, MODE_SAME_X,
                                    MODE_FLIPPED, MODE_OFF_LINE, MODE_OVERLAP};

  logic clk;
  logic reset;
  logic oam_wr;
  logic [3:0] oam_index;
  ppu_obj_pkg::obj_entry_t oam_entry;
  logic line_start;
  ppu_obj_pkg::pixel_coord_t ly;
  logic drawing;
  logic vram_rd;
  ppu_obj_pkg::vram_addr_t vram_addr;
  logic [7:0] vram_rdata = 8'h00;
  logic pixel_valid;
  ppu_obj_pkg::pixel_coord_t pixel_out_x;
  ppu_obj_pkg::obj_color_t pixel_color;

  logic [7:0] vram_mem [4096];
  logic [31:0] lfsr_q;
  logic rd_req = 1'b0;
  logic [11:0] rd_addr;
  ppu_obj_pkg::obj_entry_t objs [MAX_SPRITES];
  ppu_obj_pkg::pixel_coord_t cur_ly;
  logic [1:0] exp_colors [160];
  string cur_name;
  int seen = 0;
  int color_errors = 0;
  int order_errors = 0;
  int bus_errors = 0;
  logic stall_prev = 1'b0;

  obj_render_top #(.MAX_SPRITES(MAX_SPRITES)) i_obj_render_top (
    .clk, .reset, .oam_wr, .oam_index, .oam_entry, .line_start, .ly, .drawing,
    .vram_rd, .vram_addr, .vram_rdata, .pixel_valid, .pixel_out_x, .pixel_color
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  // colour at x: opaque pixel of the leftmost object, lowest index on a tie
  function automatic logic [1:0] ref_color(input int x);
    logic [1:0] best;
    logic [1:0] c;
    logic [7:0] row;
    logic [11:0] addr;
    logic [2:0] bitn;
    int best_x;
    int col;
    best = 2'd0;
    best_x = 1000;
    for (int i = 0; i < MAX_SPRITES; i++) begin
      row = cur_ly + 8'd16 - objs[i].y_pos;
      col = x - (int'(objs[i].x_pos) - 8);
      if (objs[i].valid && row < 8'd8 && col >= 0 && col < 8) begin
        if (objs[i].attr[6]) begin
          row = 8'd7 - row;
        end
        addr = {objs[i].tile_idx, row[2:0], 1'b0};
        bitn = objs[i].attr[5] ? 3'(col) : 3'(7 - col);
        c = {vram_mem[addr + 12'd1][bitn], vram_mem[addr][bitn]};
        if (c != 2'd0 && int'(objs[i].x_pos) < best_x) begin
          best = c;
          best_x = int'(objs[i].x_pos);
        end
      end
    end
    return best;
  endfunction

  task automatic place_objects(input int r);
    int xp;
    int yrow;
    int base;
    base = (modes[r] == MODE_OVERLAP) ? 8 + take_bits(6) : 8 + take_bits(7);
    for (int i = 0; i < MAX_SPRITES; i++) begin
      objs[i] = '0;
      yrow = take_bits(3);
      objs[i].y_pos = 8'(int'(cur_ly) + 16 - yrow);
      objs[i].tile_idx = 8'(take_bits(8));
      objs[i].valid = (i < counts[r]);
      case (modes[r])
        MODE_OVERLAP: xp = base + i * 4 + take_bits(2);
        MODE_SAME_X: xp = base;
        default: xp = 8 + i * 16 + take_bits(3);
      endcase
      objs[i].x_pos = 8'(xp);
      if (modes[r] == MODE_FLIPPED) begin
        objs[i].attr = {1'b0, i[1], i[0], 5'b0};
      end
      // even entries miss the line, odd entries are invalid
      if (modes[r] == MODE_OFF_LINE && i % 2 == 0) begin
        objs[i].y_pos = 8'(int'(cur_ly) + 17 + yrow);
      end else if (modes[r] == MODE_OFF_LINE) begin
        objs[i].valid = 1'b0;
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic run_line(input int r);
    cur_name = names[r];
    cur_ly = 8'(lines[r]);
    place_objects(r);
    for (int x = 0; x < 160; x++) begin
      exp_colors[x] = ref_color(x);
    end
    for (int i = 0; i < MAX_SPRITES; i++) begin
      next_cycle();
      oam_wr = 1'b1;
      oam_index = 4'(i);
      oam_entry = objs[i];
    end
    next_cycle();
    oam_wr = 1'b0;
    line_start = 1'b1;
    ly = cur_ly;
    next_cycle();
    line_start = 1'b0;
    drawing = 1'b1;
    while (seen < 160) begin
      @(posedge clk);
    end
    // a few more cycles to catch a pixel past the end of the line
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    drawing = 1'b0;
  endtask

  // video memory answers one cycle after the read strobe
  always @(negedge clk) begin
    rd_req = vram_rd;
    rd_addr = vram_addr[11:0];
    if (vram_rd) begin
      assert (vram_addr[15:12] == 4'h8) else begin
        $display("%s: video memory read at %h lies outside object tile data",
                 cur_name, vram_addr);
        bus_errors++;
      end
    end
  end

  always @(posedge clk) begin
    #DRIVE_DELAY;
    if (rd_req) begin
      vram_rdata = vram_mem[rd_addr];
    end
  end

  // output monitor, sampled mid cycle
  always @(negedge clk) begin
    if (line_start) begin
      seen = 0;
    end
    if (pixel_valid) begin
      assert (!stall_prev) else begin
        $display("%s: a pixel left the mixer while stall was high", cur_name);
        order_errors++;
      end
      assert (seen < 160) else begin
        $display("%s: more than 160 pixels were emitted on the line", cur_name);
        order_errors++;
      end
      if (seen < 160) begin
        assert (int'(pixel_out_x) == seen) else begin
          $display("%s: pixel x %0d came where x %0d was due", cur_name, pixel_out_x, seen);
          order_errors++;
        end
        assert (pixel_color == exp_colors[seen]) else begin
          $display("** Error %s x=%0d: expected %0d, actual %0d",
                   cur_name, seen, exp_colors[seen], pixel_color);
          color_errors++;
        end
        seen++;
      end
    end
    stall_prev = i_obj_render_top.stall;
  end

  initial begin
    reset = 1'b1;
    oam_wr = 1'b0;
    oam_index = '0;
    oam_entry = '0;
    line_start = 1'b0;
    ly = '0;
    drawing = 1'b0;
    lfsr_q = 32'h5a2347e3;
    for (int a = 0; a < 4096; a++) begin
      vram_mem[a] = 8'(take_bits(8));
    end
    repeat (16) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_line(r);
    end
    $display("pixel errors %0d, sequence errors %0d, read errors %0d",
             color_errors, order_errors, bus_errors);
    if (color_errors == 0 && order_errors == 0 && bus_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the lines did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
